// ==== hw/ooo_pkg.sv ====
// sizes, opcode enum and packed structs shared by the core
`default_nettype none

package ooo_pkg;

   //////////////////////////////
   // sizes
   //////////////////////////////
   localparam int data_width  = 32;
   localparam int num_regs    = 16;
   // power of two, pointers wrap on their own
   localparam int rob_depth   = 8;
   localparam int rs_depth    = 4;
   localparam int mult_stages = 3;

   typedef logic [$clog2(num_regs)-1:0]  reg_idx_t;
   // rob index doubles as rename tag
   typedef logic [$clog2(rob_depth)-1:0] rob_tag_t;

   typedef enum logic [2:0] {
      op_li,
      op_add,
      op_sub,
      op_and,
      op_xor,
      op_mul
   } op_e;

   //////////////////////////////
   // packets
   //////////////////////////////
   typedef struct packed {
      op_e         op;
      reg_idx_t    rd;
      reg_idx_t    rs1;
      reg_idx_t    rs2;
      logic [15:0] imm;
   } inst_t;

   typedef struct packed {
      logic                  ready;
      rob_tag_t              tag;
      logic [data_width-1:0] value;
   } operand_t;

   // no valid bit here
   // alu slot idles with op_mul, mult slot with anything but op_mul
   typedef struct packed {
      op_e                   op;
      rob_tag_t              tag;
      logic [data_width-1:0] opa;
      logic [data_width-1:0] opb;
   } issue_t;

   typedef struct packed {
      logic                  valid;
      rob_tag_t              tag;
      logic [data_width-1:0] value;
   } cdb_t;

   typedef struct packed {
      logic                  valid;
      reg_idx_t              rd;
      logic [data_width-1:0] value;
   } commit_t;

endpackage

`default_nettype wire

// ==== hw/register_map.sv ====
// architectural register file, rename tags and dispatch operand read
`timescale 1ns/1ps
`default_nettype none

module register_map (
   input  wire                    clock,
   input  wire                    reset,
   input  wire                    dispatch_fire,
   input  wire ooo_pkg::inst_t    dispatch_inst,
   input  wire ooo_pkg::rob_tag_t dispatch_tag,
   input  wire ooo_pkg::cdb_t     cdb,
   input  wire ooo_pkg::commit_t  commit,
   output ooo_pkg::operand_t      src1,
   output ooo_pkg::operand_t      src2
);

   logic [ooo_pkg::data_width-1:0] arch_value [ooo_pkg::num_regs];
   // result seen on the bus but not yet retired
   logic [ooo_pkg::data_width-1:0] fwd_value [ooo_pkg::num_regs];
   ooo_pkg::rob_tag_t              pend_tag [ooo_pkg::num_regs];
   logic [ooo_pkg::num_regs-1:0]   pending;
   logic [ooo_pkg::num_regs-1:0]   have_value;
   // tracks the rob head, retirement is in order
   ooo_pkg::rob_tag_t              retire_tag;

   function automatic ooo_pkg::operand_t lookup(input ooo_pkg::reg_idx_t idx);
      ooo_pkg::operand_t opnd;
      opnd.ready = 1'b1;
      opnd.tag   = pend_tag[idx];
      opnd.value = arch_value[idx];
      if (pending[idx]) begin
         opnd.ready = have_value[idx];
         opnd.value = fwd_value[idx];
         // same-cycle bus bypass
         if (cdb.valid && cdb.tag == pend_tag[idx]) begin
            opnd.ready = 1'b1;
            opnd.value = cdb.value;
         end
      end
      return opnd;
   endfunction

   always_comb begin
      src1 = lookup(dispatch_inst.rs1);
      src2 = lookup(dispatch_inst.rs2);
   end

   always_ff @(posedge clock) begin
      if (reset) begin
         pending    <= '0;
         have_value <= '0;
         retire_tag <= '0;
         for (int r = 0; r < ooo_pkg::num_regs; r++) begin
            arch_value[r] <= '0;
         end
      end else begin
         for (int r = 0; r < ooo_pkg::num_regs; r++) begin
            if (cdb.valid && pending[r] && cdb.tag == pend_tag[r]) begin
               have_value[r] <= 1'b1;
               fwd_value[r]  <= cdb.value;
            end
         end
         if (commit.valid) begin
            arch_value[commit.rd] <= commit.value;
            retire_tag            <= retire_tag + 1'b1;
            // a younger writer keeps its tag
            if (pend_tag[commit.rd] == retire_tag) begin
               pending[commit.rd] <= 1'b0;
            end
         end
         // new rename wins over clear and capture
         if (dispatch_fire) begin
            pending[dispatch_inst.rd]    <= 1'b1;
            have_value[dispatch_inst.rd] <= 1'b0;
            pend_tag[dispatch_inst.rd]   <= dispatch_tag;
         end
      end
   end

endmodule

`default_nettype wire

// ==== hw/reorder_buffer.sv ====
// circular reorder buffer: allocate, mark done from the bus, retire in order
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer (
   input  wire                    clock,
   input  wire                    reset,
   input  wire                    dispatch_fire,
   input  wire ooo_pkg::reg_idx_t dispatch_rd,
   input  wire ooo_pkg::cdb_t     cdb,
   output ooo_pkg::rob_tag_t      alloc_tag,
   output logic                   full,
   output ooo_pkg::commit_t       commit
);

   typedef logic [$clog2(ooo_pkg::rob_depth):0] count_t;

   logic [ooo_pkg::rob_depth-1:0]  done;
   ooo_pkg::reg_idx_t              dest [ooo_pkg::rob_depth];
   logic [ooo_pkg::data_width-1:0] result [ooo_pkg::rob_depth];
   ooo_pkg::rob_tag_t              head;
   ooo_pkg::rob_tag_t              tail;
   count_t                         count;
   logic                           retire;

   // head leaves on the edge after its completion
   assign retire    = (count != '0) && done[head];
   assign alloc_tag = tail;
   assign full      = (count == count_t'(ooo_pkg::rob_depth));

   always_comb begin
      commit.valid = retire;
      commit.rd    = dest[head];
      commit.value = result[head];
   end

   //////////////////////////////
   // pointers and done bits
   //////////////////////////////
   always_ff @(posedge clock) begin
      if (reset) begin
         head  <= '0;
         tail  <= '0;
         count <= '0;
         done  <= '0;
      end else begin
         if (cdb.valid) begin
            done[cdb.tag] <= 1'b1;
         end
         if (dispatch_fire) begin
            done[tail] <= 1'b0;
            tail       <= tail + 1'b1;
         end
         if (retire) begin
            head <= head + 1'b1;
         end
         count <= count + count_t'(dispatch_fire) - count_t'(retire);
      end
   end

   // entry payload
   always_ff @(posedge clock) begin
      if (dispatch_fire) begin
         dest[tail] <= dispatch_rd;
      end
      if (cdb.valid) begin
         result[cdb.tag] <= cdb.value;
      end
   end

endmodule

`default_nettype wire

// ==== hw/reservation_station.sv ====
// reservation station: operand wait, bus capture, oldest-first issue select
`timescale 1ns/1ps
`default_nettype none

module reservation_station (
   input  wire                    clock,
   input  wire                    reset,
   input  wire                    dispatch_fire,
   input  wire ooo_pkg::inst_t    dispatch_inst,
   input  wire ooo_pkg::rob_tag_t dispatch_tag,
   input  wire ooo_pkg::operand_t src1,
   input  wire ooo_pkg::operand_t src2,
   input  wire ooo_pkg::cdb_t     cdb,
   input  wire                    alu_busy,
   output logic                   full,
   output ooo_pkg::issue_t        alu_issue,
   output ooo_pkg::issue_t        mult_issue
);

   typedef logic [$clog2(ooo_pkg::rs_depth)-1:0] slot_t;

   typedef struct packed {
      logic              busy;
      ooo_pkg::op_e      op;
      ooo_pkg::rob_tag_t tag;
      ooo_pkg::operand_t src1;
      ooo_pkg::operand_t src2;
   } entry_t;

   entry_t                       entries [ooo_pkg::rs_depth];
   entry_t                       fill;
   // older[i][j] set when entry i arrived before entry j
   logic [ooo_pkg::rs_depth-1:0] older [ooo_pkg::rs_depth];
   logic [ooo_pkg::rs_depth-1:0] busy;
   logic [ooo_pkg::rs_depth-1:0] ready;
   logic [ooo_pkg::rs_depth-1:0] alu_cand;
   logic [ooo_pkg::rs_depth-1:0] mult_cand;
   logic [ooo_pkg::rs_depth-1:0] alu_sel;
   logic [ooo_pkg::rs_depth-1:0] mult_sel;
   slot_t                        free_slot;
   slot_t                        alu_slot;
   slot_t                        mult_slot;

   function automatic ooo_pkg::issue_t to_issue(input entry_t e);
      return '{e.op, e.tag, e.src1.value, e.src2.value};
   endfunction

   // new entry, li takes the sign-extended immediate as its only operand
   always_comb begin
      fill.busy = 1'b1;
      fill.op   = dispatch_inst.op;
      fill.tag  = dispatch_tag;
      fill.src1 = src1;
      fill.src2 = src2;
      if (dispatch_inst.op == ooo_pkg::op_li) begin
         fill.src1.ready = 1'b1;
         fill.src1.value = {{(ooo_pkg::data_width-16){dispatch_inst.imm[15]}}, dispatch_inst.imm};
         fill.src2.ready = 1'b1;
      end
   end

   //////////////////////////////
   // issue select
   //////////////////////////////
   always_comb begin
      for (int i = 0; i < ooo_pkg::rs_depth; i++) begin
         busy[i]      = entries[i].busy;
         ready[i]     = entries[i].busy && entries[i].src1.ready && entries[i].src2.ready;
         alu_cand[i]  = ready[i] && entries[i].op != ooo_pkg::op_mul && !alu_busy;
         mult_cand[i] = ready[i] && entries[i].op == ooo_pkg::op_mul;
      end
   end

   // drop any candidate that has an older candidate
   always_comb begin
      alu_sel  = alu_cand;
      mult_sel = mult_cand;
      for (int i = 0; i < ooo_pkg::rs_depth; i++) begin
         for (int j = 0; j < ooo_pkg::rs_depth; j++) begin
            if (alu_cand[j] && older[j][i]) alu_sel[i] = 1'b0;
            if (mult_cand[j] && older[j][i]) mult_sel[i] = 1'b0;
         end
      end
   end

   always_comb begin
      free_slot = '0;
      alu_slot  = '0;
      mult_slot = '0;
      for (int i = ooo_pkg::rs_depth - 1; i >= 0; i--) begin
         if (!busy[i]) free_slot = slot_t'(i);
         if (alu_sel[i]) alu_slot = slot_t'(i);
         if (mult_sel[i]) mult_slot = slot_t'(i);
      end
   end

   assign full = &busy;

   //////////////////////////////
   // entry state
   //////////////////////////////
   always_ff @(posedge clock) begin
      if (reset) begin
         for (int i = 0; i < ooo_pkg::rs_depth; i++) begin
            entries[i].busy <= 1'b0;
            older[i]        <= '0;
         end
         alu_issue.op  <= ooo_pkg::op_mul;
         mult_issue.op <= ooo_pkg::op_li;
      end else begin
         // bus capture for waiting operands
         for (int i = 0; i < ooo_pkg::rs_depth; i++) begin
            if (cdb.valid && !entries[i].src1.ready && entries[i].src1.tag == cdb.tag) begin
               entries[i].src1.ready <= 1'b1;
               entries[i].src1.value <= cdb.value;
            end
            if (cdb.valid && !entries[i].src2.ready && entries[i].src2.tag == cdb.tag) begin
               entries[i].src2.ready <= 1'b1;
               entries[i].src2.value <= cdb.value;
            end
         end
         // one-cycle strobes, idle unless a slot was picked
         alu_issue.op  <= ooo_pkg::op_mul;
         mult_issue.op <= ooo_pkg::op_li;
         if (|alu_sel) begin
            entries[alu_slot].busy <= 1'b0;
            alu_issue              <= to_issue(entries[alu_slot]);
         end
         if (|mult_sel) begin
            entries[mult_slot].busy <= 1'b0;
            mult_issue              <= to_issue(entries[mult_slot]);
         end
         // fill overrides any capture aimed at a free slot
         if (dispatch_fire) begin
            entries[free_slot] <= fill;
            for (int j = 0; j < ooo_pkg::rs_depth; j++) begin
               older[free_slot][j] <= 1'b0;
               older[j][free_slot] <= busy[j];
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== hw/exec_units.sv ====
// alu with one-entry result hold, and pipelined multiplier
`timescale 1ns/1ps
`default_nettype none

module exec_units (
   input  wire                  clock,
   input  wire                  reset,
   input  wire ooo_pkg::issue_t alu_issue,
   input  wire ooo_pkg::issue_t mult_issue,
   input  wire                  alu_grant,
   output ooo_pkg::cdb_t        alu_result,
   output ooo_pkg::cdb_t        mult_result,
   output logic                 alu_busy
);

   ooo_pkg::cdb_t                    alu_hold;
   ooo_pkg::cdb_t                    mult_pipe [ooo_pkg::mult_stages];
   logic [ooo_pkg::data_width-1:0]   alu_value;
   logic [2*ooo_pkg::data_width-1:0] product;
   logic                             alu_fire;
   logic                             mult_fire;

   assign alu_fire  = (alu_issue.op != ooo_pkg::op_mul);
   assign mult_fire = (mult_issue.op == ooo_pkg::op_mul);

   //////////////////////////////
   // alu
   //////////////////////////////
   always_comb begin
      case (alu_issue.op)
         ooo_pkg::op_add: alu_value = alu_issue.opa + alu_issue.opb;
         ooo_pkg::op_sub: alu_value = alu_issue.opa - alu_issue.opb;
         ooo_pkg::op_and: alu_value = alu_issue.opa & alu_issue.opb;
         ooo_pkg::op_xor: alu_value = alu_issue.opa ^ alu_issue.opb;
         // li passes its immediate through
         default:         alu_value = alu_issue.opa;
      endcase
   end

   // stall the station while the hold is stuck, or while the result now
   // in flight will meet a multiplier result on the next cycle
   assign alu_busy = (alu_hold.valid && !alu_grant) ||
                     (alu_fire && mult_pipe[ooo_pkg::mult_stages-2].valid);

   // multiply formed in the first stage, later stages only retime it
   assign product = mult_issue.opa * mult_issue.opb;

   always_ff @(posedge clock) begin
      if (reset) begin
         alu_hold.valid <= 1'b0;
         for (int s = 0; s < ooo_pkg::mult_stages; s++) begin
            mult_pipe[s].valid <= 1'b0;
         end
      end else begin
         if (alu_fire) begin
            alu_hold <= '{1'b1, alu_issue.tag, alu_value};
         end else if (alu_grant) begin
            alu_hold.valid <= 1'b0;
         end
         mult_pipe[0] <= '{mult_fire, mult_issue.tag, product[ooo_pkg::data_width-1:0]};
         for (int s = 1; s < ooo_pkg::mult_stages; s++) begin
            mult_pipe[s] <= mult_pipe[s-1];
         end
      end
   end

   assign alu_result  = alu_hold;
   assign mult_result = mult_pipe[ooo_pkg::mult_stages-1];

endmodule

`default_nettype wire

// ==== hw/cdb_arbiter.sv ====
// fixed-priority common data bus arbiter
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter (
   input  wire ooo_pkg::cdb_t alu_result,
   input  wire ooo_pkg::cdb_t mult_result,
   output ooo_pkg::cdb_t      cdb,
   output logic               alu_grant
);

   // multiplier first, its pipe has no stall
   // an idle alu hold leaves the bus invalid
   always_comb begin
      if (mult_result.valid) begin
         cdb       = mult_result;
         alu_grant = 1'b0;
      end else begin
         cdb       = alu_result;
         alu_grant = alu_result.valid;
      end
   end

endmodule

`default_nettype wire

// ==== hw/ooo_core.sv ====
// core top: map, rob, station, execution units and bus arbiter
`timescale 1ns/1ps
`default_nettype none

module ooo_core (
   input  wire                 clock,
   input  wire                 reset,
   input  wire                 dispatch_valid,
   input  wire ooo_pkg::inst_t dispatch_inst,
   output logic                dispatch_ready,
   output ooo_pkg::commit_t    commit
);

   ooo_pkg::operand_t src1;
   ooo_pkg::operand_t src2;
   ooo_pkg::rob_tag_t alloc_tag;
   ooo_pkg::issue_t   alu_issue;
   ooo_pkg::issue_t   mult_issue;
   ooo_pkg::cdb_t     alu_result;
   ooo_pkg::cdb_t     mult_result;
   ooo_pkg::cdb_t     cdb;
   logic              rob_full;
   logic              rs_full;
   logic              dispatch_fire;
   logic              alu_busy;
   logic              alu_grant;

   //////////////////////////////
   // dispatch
   //////////////////////////////
   assign dispatch_ready = !rob_full && !rs_full;
   assign dispatch_fire  = dispatch_valid && dispatch_ready;

   register_map i_register_map (
      .clock         (clock),
      .reset         (reset),
      .dispatch_fire (dispatch_fire),
      .dispatch_inst (dispatch_inst),
      .dispatch_tag  (alloc_tag),
      .cdb           (cdb),
      .commit        (commit),
      .src1          (src1),
      .src2          (src2)
   );

   reorder_buffer i_reorder_buffer (
      .clock         (clock),
      .reset         (reset),
      .dispatch_fire (dispatch_fire),
      .dispatch_rd   (dispatch_inst.rd),
      .cdb           (cdb),
      .alloc_tag     (alloc_tag),
      .full          (rob_full),
      .commit        (commit)
   );

   reservation_station i_reservation_station (
      .clock         (clock),
      .reset         (reset),
      .dispatch_fire (dispatch_fire),
      .dispatch_inst (dispatch_inst),
      .dispatch_tag  (alloc_tag),
      .src1          (src1),
      .src2          (src2),
      .cdb           (cdb),
      .alu_busy      (alu_busy),
      .full          (rs_full),
      .alu_issue     (alu_issue),
      .mult_issue    (mult_issue)
   );

   //////////////////////////////
   // execute and broadcast
   //////////////////////////////
   exec_units i_exec_units (
      .clock       (clock),
      .reset       (reset),
      .alu_issue   (alu_issue),
      .mult_issue  (mult_issue),
      .alu_grant   (alu_grant),
      .alu_result  (alu_result),
      .mult_result (mult_result),
      .alu_busy    (alu_busy)
   );

   cdb_arbiter i_cdb_arbiter (
      .alu_result  (alu_result),
      .mult_result (mult_result),
      .cdb         (cdb),
      .alu_grant   (alu_grant)
   );

endmodule

`default_nettype wire

// ==== dv/core_properties.sv ====
// bound assertions: dispatch handshake, commit strobe, multiplier latency
`timescale 1ns/1ps
`default_nettype none

module core_properties (
   input wire                   clock,
   input wire                   reset,
   input wire                   dispatch_valid,
   input wire                   dispatch_ready,
   input wire ooo_pkg::commit_t commit,
   input wire ooo_pkg::issue_t  mult_issue,
   input wire ooo_pkg::cdb_t    mult_result
);

   // accepted dispatches not yet retired
   int in_flight;

   always_ff @(posedge clock) begin
      if (reset) begin
         in_flight <= 0;
      end else begin
         in_flight <= in_flight + int'(dispatch_valid && dispatch_ready) - int'(commit.valid);
      end
   end

   // valid only rises into an open slot
   valid_rises_when_ready: assert property (@(posedge clock) disable iff (reset)
      $rose(dispatch_valid) |-> dispatch_ready)
      else $error("dispatch_valid rose while dispatch_ready was low");

   // one commit port, each strobe retires one earlier dispatch
   commit_follows_dispatch: assert property (@(posedge clock) disable iff (reset)
      commit.valid |-> in_flight > 0)
      else $error("commit strobe with no outstanding dispatch");

   // rob empty once reset has been seen for a cycle
   no_commit_in_reset: assert property (@(posedge clock)
      reset && $past(reset) |-> !commit.valid)
      else $error("commit strobe during reset");

   // fixed multiplier latency, pipe never stalls
   mult_latency: assert property (@(posedge clock) disable iff (reset)
      mult_issue.op == ooo_pkg::op_mul |-> ##(ooo_pkg::mult_stages) mult_result.valid)
      else $error("multiplier result missing after issue");

endmodule

bind ooo_core core_properties i_core_properties (
   .clock          (clock),
   .reset          (reset),
   .dispatch_valid (dispatch_valid),
   .dispatch_ready (dispatch_ready),
   .commit         (commit),
   .mult_issue     (mult_issue),
   .mult_result    (mult_result)
);

`default_nettype wire

// ==== dv/core_tb.sv ====
// testbench for the core: vector replay, commit checks, timeout and summary
`timescale 1ns/1ps
`default_nettype none

module core_tb;

   localparam int max_vectors  = 64;
   localparam int reset_cycles = 10;

   // one line of the vectors file
   typedef struct packed {
      logic [3:0]  op;
      logic [3:0]  rd;
      logic [3:0]  rs1;
      logic [3:0]  rs2;
      logic [15:0] imm;
      logic [31:0] expected;
   } vector_t;

   logic             clock;
   logic             reset;
   logic             dispatch_valid;
   ooo_pkg::inst_t   dispatch_inst;
   logic             dispatch_ready;
   ooo_pkg::commit_t commit;

   logic [63:0] raw [max_vectors];
   vector_t     vectors [max_vectors];
   // commit values of the back-to-back pass
   logic [31:0] first_stream [max_vectors];
   logic [31:0] lcg_state;
   logic        saw_stall;
   int          num_vectors;
   int          pass_index;
   int          accepted;
   int          committed;
   // every commit strobe, stray ones included
   int          commit_strobes;
   int          mismatches;
   int          other_errors;
   int          cycle_count;
   int          timeout_limit;

   ooo_core i_dut (
      .clock          (clock),
      .reset          (reset),
      .dispatch_valid (dispatch_valid),
      .dispatch_inst  (dispatch_inst),
      .dispatch_ready (dispatch_ready),
      .commit         (commit)
   );

   // 4 ns period
   always #2 clock = ~clock;

   //////////////////////////////
   // helpers
   //////////////////////////////
   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   task automatic expect_equal(input string what, input logic [31:0] got,
                               input logic [31:0] want);
      if (got !== want) begin
         mismatches++;
         $display("[FAIL] t=%0d ns: %s: got %h, expected %h", $time, what, got, want);
      end
   endtask

   // reference semantics of each opcode
   function automatic logic [31:0] model_result(input vector_t v, input logic [31:0] a,
                                                input logic [31:0] b);
      case (ooo_pkg::op_e'(v.op[2:0]))
         ooo_pkg::op_li:  return {{16{v.imm[15]}}, v.imm};
         ooo_pkg::op_add: return a + b;
         ooo_pkg::op_sub: return a - b;
         ooo_pkg::op_and: return a & b;
         ooo_pkg::op_xor: return a ^ b;
         // low half of the product
         ooo_pkg::op_mul: return 32'(a * b);
         default:         return '0;
      endcase
   endfunction

   function automatic ooo_pkg::inst_t to_inst(input vector_t v);
      ooo_pkg::inst_t inst;
      inst.op  = ooo_pkg::op_e'(v.op[2:0]);
      inst.rd  = v.rd;
      inst.rs1 = v.rs1;
      inst.rs2 = v.rs2;
      inst.imm = v.imm;
      return inst;
   endfunction

   task automatic load_vectors();
      logic [31:0] regs [ooo_pkg::num_regs];
      logic [31:0] value;
      // marker with an invalid opcode ends the list
      for (int i = 0; i < max_vectors; i++) begin
         raw[i] = {4'hf, 60'(i)};
      end
      $readmemh("dv/core_vectors.txt", raw);
      num_vectors = 0;
      while (num_vectors < max_vectors && raw[num_vectors][63:60] != 4'hf) begin
         vectors[num_vectors] = raw[num_vectors];
         num_vectors++;
      end
      // program-order model against the expected column
      for (int r = 0; r < ooo_pkg::num_regs; r++) begin
         regs[r] = '0;
      end
      for (int i = 0; i < num_vectors; i++) begin
         value = model_result(vectors[i], regs[vectors[i].rs1], regs[vectors[i].rs2]);
         expect_equal($sformatf("vector %0d expected column", i), vectors[i].expected, value);
         regs[vectors[i].rd] = value;
      end
   endtask

   task automatic apply_reset();
      reset          <= 1'b1;
      dispatch_valid <= 1'b0;
      repeat (reset_cycles) @(posedge clock);
      accepted = 0;
      reset <= 1'b0;
      @(negedge clock);
      expect_equal("dispatch_ready after reset", 32'(dispatch_ready), 32'd1);
      expect_equal("commit strobe after reset", 32'(commit.valid), 32'd0);
   endtask

   //////////////////////////////
   // dispatch driver
   //////////////////////////////
   task automatic run_pass(input bit random_gaps);
      logic rdy;
      logic vld;
      int   idx;
      int   gap;
      idx = 0;
      gap = 0;
      while (idx < num_vectors) begin
         @(negedge clock);
         rdy = dispatch_ready;
         vld = dispatch_valid;
         @(posedge clock);
         if (vld && rdy) begin
            // accepted on this edge
            idx++;
            accepted++;
            gap = random_gaps ? int'((next_random() >> 16) % 32'd4) : 0;
            if (idx < num_vectors && gap == 0) begin
               dispatch_inst <= to_inst(vectors[idx]);
            end else begin
               dispatch_valid <= 1'b0;
            end
         end else if (!vld) begin
            if (gap > 0) gap--;
            // idle cycle, occupancy cannot grow, so ready stays high
            if (gap == 0 && rdy) begin
               dispatch_valid <= 1'b1;
               dispatch_inst  <= to_inst(vectors[idx]);
            end
         end
      end
      // drain, then look for stray commits
      while (committed < num_vectors) @(posedge clock);
      repeat (10) @(posedge clock);
      expect_equal($sformatf("pass %0d commits vs dispatches", pass_index),
                   32'(commit_strobes), 32'(accepted));
   endtask

   //////////////////////////////
   // commit monitor
   //////////////////////////////
   task automatic record_commit();
      if (committed >= accepted) begin
         other_errors++;
         $display("error: commit at %0d ns has no outstanding dispatch", $time);
      end else begin
         expect_equal($sformatf("pass %0d commit %0d rd", pass_index, committed),
                      32'(commit.rd), 32'(vectors[committed].rd));
         expect_equal($sformatf("pass %0d commit %0d value", pass_index, committed),
                      commit.value, vectors[committed].expected);
         if (pass_index == 0) begin
            first_stream[committed] = commit.value;
         end else begin
            expect_equal($sformatf("commit %0d vs back-to-back pass", committed),
                         commit.value, first_stream[committed]);
         end
         committed++;
      end
   endtask

   // outputs settle by the falling edge
   always @(negedge clock) begin
      if (reset) begin
         committed      = 0;
         commit_strobes = 0;
      end else begin
         if (!dispatch_ready) saw_stall = 1'b1;
         if (commit.valid) begin
            commit_strobes++;
            record_commit();
         end
      end
   end

   always @(posedge clock) begin
      cycle_count++;
      if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
         $display("error: timeout after %0d cycles, %0d of %0d commits seen in pass %0d",
                  cycle_count, committed, num_vectors, pass_index);
         $display("Simulation FAILED");
         $finish;
      end
   end

   //////////////////////////////
   // main sequence
   //////////////////////////////
   initial begin
      clock          = 1'b0;
      reset          <= 1'b1;
      dispatch_valid <= 1'b0;
      dispatch_inst  <= '0;
      lcg_state      = 32'hda2a_ca96;
      saw_stall      = 1'b0;
      pass_index     = 0;
      accepted       = 0;
      committed      = 0;
      commit_strobes = 0;
      mismatches     = 0;
      other_errors   = 0;
      cycle_count    = 0;
      timeout_limit  = 0;
      load_vectors();
      // two passes over the list
      timeout_limit = 40 * 2 * num_vectors + 100;
      if (num_vectors == 0) begin
         other_errors++;
         $display("error: no vectors could be read from dv/core_vectors.txt");
      end else begin
         apply_reset();
         run_pass(1'b0);
         expect_equal("dispatch_ready dropped under load", 32'(saw_stall), 32'd1);
         pass_index = 1;
         apply_reset();
         run_pass(1'b1);
      end
      $display("summary: %0d vectors, %0d value mismatches, %0d other errors",
               num_vectors, mismatches, other_errors);
      if (mismatches == 0 && other_errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== build.f ====
hw/ooo_pkg.sv
hw/register_map.sv
hw/reorder_buffer.sv
hw/reservation_station.sv
hw/exec_units.sv
hw/cdb_arbiter.sv
hw/ooo_core.sv
dv/core_properties.sv
dv/core_tb.sv

// ==== Makefile ====
# Verilator build and run for the out-of-order core testbench

SOURCES := $(shell grep -v '^+' build.f)

obj_dir/Vcore_tb: build.f $(SOURCES)
	verilator --binary -j 0 -Wno-fatal --top-module core_tb -f build.f

.PHONY: run clean

# pass only when the testbench prints its pass line
run: obj_dir/Vcore_tb
	./obj_dir/Vcore_tb | awk '{ print } /^Simulation PASSED$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

// ==== dv/core_vectors.txt ====
// columns: op_rd_rs1_rs2_imm_expected, one hex word per instruction
// op codes: 0 li, 1 add, 2 sub, 3 and, 4 xor, 5 mul
0_1_0_0_0005_00000005
0_2_0_0_fffd_fffffffd
1_3_1_2_0000_00000002
2_4_3_1_0000_fffffffd
3_5_4_1_0000_00000005
4_6_5_2_0000_fffffff8
5_7_2_4_0000_00000009
1_8_1_1_0000_0000000a
4_9_3_1_0000_00000007
0_a_0_0_0003_00000003
5_a_a_a_0000_00000009
0_b_0_0_7fff_00007fff
0_d_0_0_0010_00000010
5_a_a_a_0000_00000051
0_c_0_0_8000_ffff8000
5_a_a_a_0000_000019a1
5_a_a_b_0000_0cd0665f
5_a_a_c_0000_ccd08000
4_f_a_d_0000_ccd08010
